/* source/baser_tx_pkg.sv */
// datapath widths, 10GBASE-R line-code constants and the block output type
package baser_tx_pkg;

    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;
    localparam int EMPTY_W = $clog2(KEEP_W);
    localparam int HDR_W = 2;

    localparam logic [7:0] ETH_PRE = 8'h55;
    localparam logic [7:0] ETH_SFD = 8'hd5;

    localparam logic [6:0] CTRL_IDLE = 7'h00;
    localparam logic [6:0] CTRL_ERROR = 7'h1e;

    localparam logic [1:0] SYNC_DATA = 2'b10;
    localparam logic [1:0] SYNC_CTRL = 2'b01;

    // block type field, first byte of a control block
    localparam logic [7:0] BLOCK_TYPE_CTRL = 8'h1e;
    localparam logic [7:0] BLOCK_TYPE_START_0 = 8'h78;
    localparam logic [7:0] BLOCK_TYPE_TERM_0 = 8'h87;
    localparam logic [7:0] BLOCK_TYPE_TERM_1 = 8'h99;
    localparam logic [7:0] BLOCK_TYPE_TERM_2 = 8'haa;
    localparam logic [7:0] BLOCK_TYPE_TERM_3 = 8'hb4;
    localparam logic [7:0] BLOCK_TYPE_TERM_4 = 8'hcc;
    localparam logic [7:0] BLOCK_TYPE_TERM_5 = 8'hd2;
    localparam logic [7:0] BLOCK_TYPE_TERM_6 = 8'he1;
    localparam logic [7:0] BLOCK_TYPE_TERM_7 = 8'hff;

    localparam logic [31:0] CRC_POLY = 32'h04c11db7; // applied bit reversed

    // next block to encode; low 3 bits of a terminate give its data byte count
    typedef enum logic [3:0] {
        OUT_IDLE   = 4'd0,
        OUT_ERROR  = 4'd1,
        OUT_START  = 4'd2,
        OUT_DATA   = 4'd4,
        OUT_TERM_0 = 4'd8,
        OUT_TERM_1 = 4'd9,
        OUT_TERM_2 = 4'd10,
        OUT_TERM_3 = 4'd11,
        OUT_TERM_4 = 4'd12,
        OUT_TERM_5 = 4'd13,
        OUT_TERM_6 = 4'd14,
        OUT_TERM_7 = 4'd15
    } output_type_e;

endpackage

/* source/baser_tx_frame_ctrl.sv */
// frame FSM: input capture, zero padding, inter-frame gap count and status pulses
module baser_tx_frame_ctrl #(
    parameter int min_frame_len = 64
) (
    input  logic                                 clk,
    input  logic                                 reset_crc,
    input  logic [baser_tx_pkg::DATA_W-1:0]      tx_tdata,
    input  logic [baser_tx_pkg::KEEP_W-1:0]      tx_tkeep,
    input  logic                                 tx_tvalid,
    input  logic                                 tx_tlast,
    input  logic                                 tx_tuser,
    output logic                                 tx_tready,
    input  logic [7:0]                           cfg_tx_ifg,
    input  logic                                 cfg_tx_enable,
    input  logic [baser_tx_pkg::DATA_W-1:0]      fcs_data_0,
    input  logic [baser_tx_pkg::DATA_W-1:0]      fcs_data_1,
    input  baser_tx_pkg::output_type_e           fcs_type_0,
    input  baser_tx_pkg::output_type_e           fcs_type_1,
    output logic [baser_tx_pkg::DATA_W-1:0]      held_data,
    output logic [baser_tx_pkg::EMPTY_W-1:0]     held_empty,
    output logic                                 crc_init,
    output logic                                 crc_update,
    output logic [baser_tx_pkg::DATA_W-1:0]      blk_data,
    output baser_tx_pkg::output_type_e           blk_type,
    output logic [15:0]                          stat_tx_pkt_len,
    output logic                                 stat_tx_pkt_good,
    output logic                                 stat_tx_pkt_bad
);

    localparam int keep_w = baser_tx_pkg::KEEP_W;
    localparam int min_len_w = $clog2(min_frame_len - 4 - keep_w + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PAYLOAD,
        ST_PAD,
        ST_FCS_1,
        ST_FCS_2,
        ST_ERR,
        ST_IFG
    } tx_state_e;

    tx_state_e state_reg, state_next;

    logic [baser_tx_pkg::DATA_W-1:0] tdata_masked;
    logic [baser_tx_pkg::EMPTY_W-1:0] tkeep_empty;
    logic [baser_tx_pkg::DATA_W-1:0] held_data_next;
    logic [baser_tx_pkg::EMPTY_W-1:0] held_empty_next;
    logic [baser_tx_pkg::DATA_W-1:0] blk_data_next;
    baser_tx_pkg::output_type_e blk_type_next;

    logic frame_reg, frame_next; // a source frame is still open
    logic tready_next;
    logic [min_len_w-1:0] min_count_reg, min_count_next;
    logic [15:0] frame_len_reg, frame_len_next;
    logic [7:0] ifg_count_reg, ifg_count_next;
    logic [7:0] ifg_min;
    logic [7:0] ifg_offset;
    logic [2:0] term_idx;
    logic [15:0] stat_len_next;
    logic stat_good_next;
    logic stat_bad_next;

    // zero unused bytes, tkeep to empty count
    always_comb begin
        tkeep_empty = 3'd7;
        for (int i = 0; i < keep_w; i++) begin
            tdata_masked[i*8 +: 8] = tx_tkeep[i] ? tx_tdata[i*8 +: 8] : 8'd0;
            if (tx_tkeep[i]) begin
                tkeep_empty = 3'(keep_w - 1 - i);
            end
        end
    end

    // idles already carried by the terminate block count toward the gap
    assign term_idx = (fcs_type_0 == baser_tx_pkg::OUT_DATA) ? fcs_type_1[2:0] : fcs_type_0[2:0];
    assign ifg_offset = 8'd7 - 8'(term_idx);
    assign ifg_min = (cfg_tx_ifg > 8'd12) ? cfg_tx_ifg : 8'd12;

    always_comb begin
        state_next = state_reg;
        crc_init = 1'b0;
        crc_update = 1'b0;
        frame_next = frame_reg;
        if (tx_tvalid && tx_tready) begin
            frame_next = !tx_tlast;
        end
        tready_next = frame_next; // keep draining a dropped frame
        min_count_next = (min_count_reg > min_len_w'(keep_w)) ?
                         min_len_w'(min_count_reg - keep_w) : '0;
        frame_len_next = frame_len_reg + 16'(keep_w);
        ifg_count_next = ifg_count_reg;
        held_data_next = held_data;
        held_empty_next = held_empty;
        blk_data_next = held_data;
        blk_type_next = baser_tx_pkg::OUT_IDLE;
        stat_len_next = '0;
        stat_good_next = 1'b0;
        stat_bad_next = 1'b0;

        case (state_reg)
            ST_IDLE: begin
                crc_init = 1'b1;
                tready_next = 1'b1;
                min_count_next = min_len_w'(min_frame_len - 4 - keep_w);
                frame_len_next = '0;
                held_data_next = tdata_masked;
                held_empty_next = tkeep_empty;
                if (tx_tvalid && tx_tready && cfg_tx_enable && !frame_reg) begin
                    blk_data_next = {baser_tx_pkg::ETH_SFD, {7{baser_tx_pkg::ETH_PRE}}};
                    blk_type_next = baser_tx_pkg::OUT_START;
                    state_next = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                crc_update = 1'b1;
                tready_next = 1'b1;
                blk_type_next = baser_tx_pkg::OUT_DATA;
                held_data_next = tdata_masked;
                held_empty_next = tkeep_empty;
                if (!tx_tvalid || tx_tlast) begin
                    tready_next = frame_next;
                    if (!tx_tvalid || tx_tuser) begin // underflow or marked bad
                        state_next = ST_ERR;
                    end else if (min_count_reg > min_len_w'(keep_w)) begin
                        held_empty_next = '0;
                        state_next = ST_PAD;
                    end else begin
                        if (min_count_reg != 0 && tkeep_empty > 3'(keep_w - min_count_reg)) begin
                            held_empty_next = 3'(keep_w - min_count_reg);
                        end
                        state_next = ST_FCS_1;
                    end
                end
            end
            ST_PAD: begin
                crc_update = 1'b1;
                blk_type_next = baser_tx_pkg::OUT_DATA;
                held_data_next = '0;
                held_empty_next = '0;
                if (min_count_reg <= min_len_w'(keep_w)) begin
                    held_empty_next = 3'(keep_w - min_count_reg);
                    state_next = ST_FCS_1;
                end
            end
            ST_FCS_1: begin
                blk_data_next = fcs_data_0;
                blk_type_next = fcs_type_0;
                ifg_count_next = ifg_min - ifg_offset;
                if (held_empty <= 3'd4) begin
                    state_next = ST_FCS_2;
                end else begin
                    stat_len_next = frame_len_reg + 16'(12 - held_empty);
                    stat_good_next = 1'b1;
                    state_next = ST_IFG;
                end
            end
            ST_FCS_2: begin
                crc_init = 1'b1;
                blk_data_next = fcs_data_1;
                blk_type_next = fcs_type_1;
                stat_len_next = frame_len_reg + 16'(4 - held_empty);
                stat_good_next = 1'b1;
                state_next = ST_IFG;
            end
            ST_ERR: begin
                blk_type_next = baser_tx_pkg::OUT_ERROR;
                ifg_count_next = ifg_min; // error block holds no idles
                stat_len_next = frame_len_reg;
                stat_bad_next = 1'b1;
                state_next = ST_IFG;
            end
            ST_IFG: begin
                crc_init = 1'b1;
                ifg_count_next = (ifg_count_reg > 8'd8) ? ifg_count_reg - 8'd8 : 8'd0;
                if (ifg_count_next == 0 && !frame_reg) begin
                    tready_next = 1'b1;
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state_reg <= ST_IDLE;
            frame_reg <= 1'b0;
            tx_tready <= 1'b0;
            ifg_count_reg <= '0;
            blk_type <= baser_tx_pkg::OUT_IDLE;
            stat_tx_pkt_len <= '0;
            stat_tx_pkt_good <= 1'b0;
            stat_tx_pkt_bad <= 1'b0;
        end else begin
            state_reg <= state_next;
            frame_reg <= frame_next;
            tx_tready <= tready_next;
            ifg_count_reg <= ifg_count_next;
            blk_type <= blk_type_next;
            stat_tx_pkt_len <= stat_len_next;
            stat_tx_pkt_good <= stat_good_next;
            stat_tx_pkt_bad <= stat_bad_next;
        end
    end

    always_ff @(posedge clk) begin
        held_data <= held_data_next;
        held_empty <= held_empty_next;
        blk_data <= blk_data_next;
        min_count_reg <= min_count_next;
        frame_len_reg <= frame_len_next;
    end

endmodule

/* source/baser_tx_fcs.sv */
// CRC-32 state registers and placement of the FCS into the closing blocks
module baser_tx_fcs (
    input  logic                                 clk,
    input  logic                                 reset_crc,
    input  logic [baser_tx_pkg::DATA_W-1:0]      held_data,
    input  logic [baser_tx_pkg::EMPTY_W-1:0]     held_empty,
    input  logic                                 crc_init,
    input  logic                                 crc_update,
    output logic [baser_tx_pkg::DATA_W-1:0]      fcs_data_0,
    output logic [baser_tx_pkg::DATA_W-1:0]      fcs_data_1,
    output baser_tx_pkg::output_type_e           fcs_type_0,
    output baser_tx_pkg::output_type_e           fcs_type_1
);

    localparam logic [31:0] poly_rev = {<<{baser_tx_pkg::CRC_POLY}};

    logic [31:0] crc_reg;
    logic [31:0] crc_next [baser_tx_pkg::KEEP_W];
    logic [2:0] last_idx; // index of the last data byte
    logic [6:0] fcs_shift;
    logic [95:0] wide_0;

    // one byte lsb first in reflected form
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            c = (c[0] ^ data[i]) ? ((c >> 1) ^ poly_rev) : (c >> 1);
        end
        return c;
    endfunction

    // state after 1..8 bytes of the held beat
    always_comb begin
        crc_next[0] = crc_byte(crc_reg, held_data[7:0]);
        for (int n = 1; n < baser_tx_pkg::KEEP_W; n++) begin
            crc_next[n] = crc_byte(crc_next[n-1], held_data[n*8 +: 8]);
        end
    end

    assign last_idx = ~held_empty;
    assign fcs_shift = {4'(last_idx) + 4'd1, 3'd0};

    // fcs goes right after the last data byte, spilling into a second block
    assign wide_0 = {32'd0, held_data} | (96'(~crc_next[last_idx]) << fcs_shift);
    assign fcs_data_0 = wide_0[63:0];
    assign fcs_data_1 = {32'd0, wide_0[95:64]};

    always_comb begin
        if (held_empty >= 3'd5) begin
            fcs_type_0 = baser_tx_pkg::output_type_e'({1'b1, last_idx + 3'd5});
            fcs_type_1 = baser_tx_pkg::OUT_IDLE;
        end else begin
            fcs_type_0 = baser_tx_pkg::OUT_DATA;
            fcs_type_1 = baser_tx_pkg::output_type_e'({1'b1, last_idx - 3'd3});
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_init) begin
            crc_reg <= '1;
        end else if (crc_update) begin
            crc_reg <= crc_next[baser_tx_pkg::KEEP_W-1];
        end
    end

endmodule

/* source/baser_tx_encoder.sv */
// 64b/66b block encoder with registered block data and sync header
module baser_tx_encoder (
    input  logic                                 clk,
    input  logic                                 reset_crc,
    input  logic [baser_tx_pkg::DATA_W-1:0]      blk_data,
    input  baser_tx_pkg::output_type_e           blk_type,
    output logic [baser_tx_pkg::DATA_W-1:0]      encoded_tx_data,
    output logic [baser_tx_pkg::HDR_W-1:0]       encoded_tx_hdr
);

    localparam logic [6:0] ci = baser_tx_pkg::CTRL_IDLE;
    localparam logic [6:0] ce = baser_tx_pkg::CTRL_ERROR;

    logic [baser_tx_pkg::DATA_W-1:0] block;
    logic [baser_tx_pkg::HDR_W-1:0] hdr;

    // terminates carry data bytes, then zero bits, then idle characters
    always_comb begin
        hdr = baser_tx_pkg::SYNC_CTRL;
        case (blk_type)
            baser_tx_pkg::OUT_IDLE:   block = {{8{ci}}, baser_tx_pkg::BLOCK_TYPE_CTRL};
            baser_tx_pkg::OUT_START:  block = {blk_data[63:8], baser_tx_pkg::BLOCK_TYPE_START_0};
            baser_tx_pkg::OUT_DATA: begin
                block = blk_data;
                hdr = baser_tx_pkg::SYNC_DATA;
            end
            baser_tx_pkg::OUT_TERM_0: block = {{7{ci}}, 7'd0, baser_tx_pkg::BLOCK_TYPE_TERM_0};
            baser_tx_pkg::OUT_TERM_1:
                block = {{6{ci}}, 6'd0, blk_data[7:0], baser_tx_pkg::BLOCK_TYPE_TERM_1};
            baser_tx_pkg::OUT_TERM_2:
                block = {{5{ci}}, 5'd0, blk_data[15:0], baser_tx_pkg::BLOCK_TYPE_TERM_2};
            baser_tx_pkg::OUT_TERM_3:
                block = {{4{ci}}, 4'd0, blk_data[23:0], baser_tx_pkg::BLOCK_TYPE_TERM_3};
            baser_tx_pkg::OUT_TERM_4:
                block = {{3{ci}}, 3'd0, blk_data[31:0], baser_tx_pkg::BLOCK_TYPE_TERM_4};
            baser_tx_pkg::OUT_TERM_5:
                block = {{2{ci}}, 2'd0, blk_data[39:0], baser_tx_pkg::BLOCK_TYPE_TERM_5};
            baser_tx_pkg::OUT_TERM_6:
                block = {ci, 1'b0, blk_data[47:0], baser_tx_pkg::BLOCK_TYPE_TERM_6};
            baser_tx_pkg::OUT_TERM_7: block = {blk_data[55:0], baser_tx_pkg::BLOCK_TYPE_TERM_7};
            default:                  block = {{8{ce}}, baser_tx_pkg::BLOCK_TYPE_CTRL}; // error too
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            encoded_tx_data <= {{8{ci}}, baser_tx_pkg::BLOCK_TYPE_CTRL};
            encoded_tx_hdr <= baser_tx_pkg::SYNC_CTRL;
        end else begin
            encoded_tx_data <= block;
            encoded_tx_hdr <= hdr;
        end
    end

endmodule

/* source/baser_tx_top.sv */
// 10GBASE-R transmitter top: frame controller, FCS unit and block encoder
module baser_tx_top #(
    parameter int min_frame_len = 64
) (
    input  logic                                 clk,
    input  logic                                 reset_crc,
    input  logic [baser_tx_pkg::DATA_W-1:0]      tx_tdata,
    input  logic [baser_tx_pkg::KEEP_W-1:0]      tx_tkeep,
    input  logic                                 tx_tvalid,
    input  logic                                 tx_tlast,
    input  logic                                 tx_tuser,
    output logic                                 tx_tready,
    input  logic [7:0]                           cfg_tx_ifg,
    input  logic                                 cfg_tx_enable,
    output logic [baser_tx_pkg::DATA_W-1:0]      encoded_tx_data,
    output logic [baser_tx_pkg::HDR_W-1:0]       encoded_tx_hdr,
    output logic [15:0]                          stat_tx_pkt_len,
    output logic                                 stat_tx_pkt_good,
    output logic                                 stat_tx_pkt_bad
);

    logic [baser_tx_pkg::DATA_W-1:0] held_data;
    logic [baser_tx_pkg::EMPTY_W-1:0] held_empty;
    logic crc_init;
    logic crc_update;
    logic [baser_tx_pkg::DATA_W-1:0] fcs_data_0;
    logic [baser_tx_pkg::DATA_W-1:0] fcs_data_1;
    baser_tx_pkg::output_type_e fcs_type_0;
    baser_tx_pkg::output_type_e fcs_type_1;
    logic [baser_tx_pkg::DATA_W-1:0] blk_data;
    baser_tx_pkg::output_type_e blk_type;

    baser_tx_frame_ctrl #(
        .min_frame_len(min_frame_len)
    ) u_frame_ctrl (
        .clk              (clk),
        .reset_crc        (reset_crc),
        .tx_tdata         (tx_tdata),
        .tx_tkeep         (tx_tkeep),
        .tx_tvalid        (tx_tvalid),
        .tx_tlast         (tx_tlast),
        .tx_tuser         (tx_tuser),
        .tx_tready        (tx_tready),
        .cfg_tx_ifg       (cfg_tx_ifg),
        .cfg_tx_enable    (cfg_tx_enable),
        .fcs_data_0       (fcs_data_0),
        .fcs_data_1       (fcs_data_1),
        .fcs_type_0       (fcs_type_0),
        .fcs_type_1       (fcs_type_1),
        .held_data        (held_data),
        .held_empty       (held_empty),
        .crc_init         (crc_init),
        .crc_update       (crc_update),
        .blk_data         (blk_data),
        .blk_type         (blk_type),
        .stat_tx_pkt_len  (stat_tx_pkt_len),
        .stat_tx_pkt_good (stat_tx_pkt_good),
        .stat_tx_pkt_bad  (stat_tx_pkt_bad)
    );

    baser_tx_fcs u_fcs (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .held_data  (held_data),
        .held_empty (held_empty),
        .crc_init   (crc_init),
        .crc_update (crc_update),
        .fcs_data_0 (fcs_data_0),
        .fcs_data_1 (fcs_data_1),
        .fcs_type_0 (fcs_type_0),
        .fcs_type_1 (fcs_type_1)
    );

    baser_tx_encoder u_encoder (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .blk_data        (blk_data),
        .blk_type        (blk_type),
        .encoded_tx_data (encoded_tx_data),
        .encoded_tx_hdr  (encoded_tx_hdr)
    );

endmodule

/* verification/baser_tx_tb.sv */
// testbench for the 10GBASE-R transmitter: stimulus, line decoder, reference CRC and checks
module baser_tx_tb;

    localparam int period = 40;
    localparam int min_data = 60; // data bytes before the FCS in a minimum frame
    localparam int frame_bytes = 100 + 20 + 72 + 69 + 66 + 72 + 64 + 48 + 24;
    localparam int watchdog_cycles = (frame_bytes / 8 + 9 * 16 + 60) * 3;
    localparam logic [63:0] idle_block = 64'h1e;
    localparam logic [63:0] err_block = {{8{7'h1e}}, 8'h1e};

    logic clk = 1'b0;
    logic reset_crc = 1'b1;
    logic [63:0] tx_tdata = '0;
    logic [7:0] tx_tkeep = '0;
    logic tx_tvalid = 1'b0;
    logic tx_tlast = 1'b0;
    logic tx_tuser = 1'b0;
    logic tx_tready;
    logic [7:0] cfg_tx_ifg = 8'd12;
    logic cfg_tx_enable = 1'b1;
    logic [63:0] encoded_tx_data;
    logic [1:0] encoded_tx_hdr;
    logic [15:0] stat_tx_pkt_len;
    logic stat_tx_pkt_good;
    logic stat_tx_pkt_bad;

    logic line_quiet = 1'b1; // only idle blocks allowed
    logic [7:0] exp_q[$];    // payload plus pad, frame after frame
    int exp_len_q[$];
    bit exp_bad_q[$];
    logic [7:0] rx_q[$];
    bit in_frame = 1'b0;
    int idle_run = 1000;     // idle characters since the last frame end
    int rx_frames = 0;
    int rx_starts = 0;
    bit stat_seen = 1'b0;
    bit stat_bad = 1'b0;
    int stat_len = 0;
    int err_count = 0;
    int check_count = 0;
    int test_mark = 0;
    wire [7:0] gap_min = (cfg_tx_ifg > 8'd12) ? cfg_tx_ifg : 8'd12;

    baser_tx_top #(.min_frame_len(64)) UUT (.*);

    always #(period / 2) clk = ~clk;

    task automatic value_error(input string msg);
        err_count++;
        $display("Error %0t: %s", $time, msg);
    endtask

    task automatic check(input bit ok, input string msg);
        check_count++;
        assert (ok) else value_error(msg);
    endtask

    function automatic int term_bytes(input logic [7:0] bt);
        case (bt)
            8'h87: return 0;
            8'h99: return 1;
            8'haa: return 2;
            8'hb4: return 3;
            8'hcc: return 4;
            8'hd2: return 5;
            8'he1: return 6;
            8'hff: return 7;
            default: return -1;
        endcase
    endfunction

    // ethernet FCS, reflected CRC-32, sent low byte first
    function automatic logic [31:0] fcs_of(input logic [7:0] d[$]);
        logic [31:0] c;
        c = 32'hffff_ffff;
        foreach (d[i]) begin
            c = c ^ {24'd0, d[i]};
            for (int b = 0; b < 8; b++) begin
                c = (c >> 1) ^ (c[0] ? 32'hedb8_8320 : 32'h0);
            end
        end
        return ~c;
    endfunction

    assert property (@(posedge clk) reset_crc |=> !tx_tready && !stat_tx_pkt_good &&
                     !stat_tx_pkt_bad && encoded_tx_hdr == 2'b01 && encoded_tx_data == idle_block)
        else value_error("outputs not quiet after reset");
    assert property (@(posedge clk) disable iff (reset_crc)
                     line_quiet |-> encoded_tx_hdr == 2'b01 && encoded_tx_data == idle_block)
        else value_error("non-idle block while the line should stay idle");
    assert property (@(posedge clk) disable iff (reset_crc)
                     stat_tx_pkt_good |=> encoded_tx_hdr == 2'b01 &&
                     term_bytes(encoded_tx_data[7:0]) >= 0)
        else value_error("good status not followed by a terminate block");
    assert property (@(posedge clk) disable iff (reset_crc)
                     stat_tx_pkt_bad |=> encoded_tx_hdr == 2'b01 && encoded_tx_data == err_block)
        else value_error("bad status not followed by an error block");
    assert property (@(posedge clk) disable iff (reset_crc) !(stat_tx_pkt_good && stat_tx_pkt_bad))
        else value_error("good and bad status in the same cycle");

    // compare a finished frame against the oldest offered one
    task automatic match_frame(input bit bad);
        logic [7:0] want[$];
        logic [31:0] fcs;
        int n;
        int pos;
        if (exp_len_q.size() == 0) begin
            value_error("frame on the line that was never offered");
            return;
        end
        n = exp_len_q.pop_front();
        check(exp_bad_q.pop_front() == bad, "frame ended with the wrong block kind");
        check(stat_seen && stat_bad == bad, "status pulse missing or of the wrong kind");
        for (int i = 0; i < n; i++) begin
            want.push_back(exp_q.pop_front());
        end
        if (!bad) begin
            check(stat_len == n + 4, $sformatf("length %0d, expected %0d", stat_len, n + 4));
            fcs = fcs_of(want);
            for (int i = 0; i < 4; i++) begin
                want.push_back(fcs[i*8 +: 8]);
            end
        end
        check(bad ? rx_q.size() <= n : rx_q.size() == n + 4,
              $sformatf("%0d bytes on the line for %0d data bytes", rx_q.size(), n));
        pos = -1;
        foreach (rx_q[i]) begin
            if (pos < 0 && (i >= want.size() || rx_q[i] != want[i])) begin
                pos = i;
            end
        end
        check(pos < 0, $sformatf("frame byte %0d differs", pos));
        stat_seen = 1'b0;
    endtask

    // line decoder, sampled mid-cycle
    always @(negedge clk) begin
        int k;
        k = term_bytes(encoded_tx_data[7:0]);
        if (!reset_crc) begin
            if (stat_tx_pkt_good || stat_tx_pkt_bad) begin
                stat_seen = 1'b1;
                stat_bad = stat_tx_pkt_bad;
                stat_len = stat_tx_pkt_len;
            end
            if (encoded_tx_hdr == 2'b10) begin
                for (int i = 0; i < 8; i++) begin
                    if (in_frame) begin
                        rx_q.push_back(encoded_tx_data[i*8 +: 8]);
                    end
                end
            end else if (encoded_tx_data[7:0] == 8'h78) begin
                check(encoded_tx_data[63:8] == 56'hd5_5555_5555_5555, "start without preamble");
                check(idle_run >= int'(gap_min),
                      $sformatf("gap of %0d idles, below %0d", idle_run, gap_min));
                rx_q.delete();
                in_frame = 1'b1;
                rx_starts++;
            end else if (k >= 0 || encoded_tx_data == err_block) begin
                for (int i = 0; i < k; i++) begin
                    rx_q.push_back(encoded_tx_data[8 + i*8 +: 8]);
                end
                idle_run = (k >= 0) ? 7 - k : 0; // idles left in a terminate
                match_frame(k < 0);
                in_frame = 1'b0;
                rx_frames++;
            end else begin
                check(encoded_tx_data == idle_block, "unknown control block on the line");
                idle_run += 8;
            end
        end
    end

    task automatic wait_ready();
        int n;
        n = 0;
        @(posedge clk);
        while (!tx_tready && n < 200) begin
            @(posedge clk);
            n++;
        end
        if (!tx_tready) begin
            err_count++;
            $display("tx_tready stayed low for 200 cycles, beat not accepted");
        end
    endtask

    // hole_after >= 0 drops tx_tvalid for one cycle after that beat
    task automatic send_frame(input int len, input bit bad_last, input int hole_after,
                              input bit on_line);
        logic [7:0] pay[$];
        logic [63:0] beat;
        logic [7:0] keep;
        int beats;
        int n;
        bit bad;
        beats = (len + 7) / 8;
        for (int i = 0; i < len; i++) begin
            pay.push_back(8'($urandom));
        end
        if (on_line) begin
            bad = bad_last || hole_after >= 0;
            n = (bad || len >= min_data) ? len : min_data;
            exp_len_q.push_back(n);
            exp_bad_q.push_back(bad);
            for (int i = 0; i < n; i++) begin
                exp_q.push_back(i < len ? pay[i] : 8'h00); // zero pad
            end
        end
        for (int b = 0; b < beats; b++) begin
            keep = '0;
            for (int i = 0; i < 8; i++) begin
                beat[i*8 +: 8] = (b * 8 + i < len) ? pay[b * 8 + i] : 8'hee;
                keep[i] = (b * 8 + i < len);
            end
            tx_tdata <= beat;
            tx_tkeep <= keep;
            tx_tvalid <= 1'b1;
            tx_tlast <= (b == beats - 1);
            tx_tuser <= bad_last && (b == beats - 1);
            wait_ready();
            if (b == hole_after) begin
                tx_tvalid <= 1'b0;
                @(posedge clk);
            end
        end
        tx_tvalid <= 1'b0;
        tx_tlast <= 1'b0;
        tx_tuser <= 1'b0;
    endtask

    task automatic wait_frames(input int target);
        int n;
        n = 0;
        while (rx_frames < target && n < 400) begin
            @(posedge clk);
            n++;
        end
        if (rx_frames < target) begin
            err_count++;
            $display("frame %0d did not end on the line within 400 cycles", target);
        end
    endtask

    task automatic end_test(input string name);
        if (err_count == test_mark) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_count - test_mark);
        end
        test_mark = err_count;
    endtask

    initial begin
        void'($urandom(65));
        repeat (2) @(posedge clk);
        reset_crc <= 1'b0;
        repeat (8) @(posedge clk);
        check(rx_starts == 0, "start block before any frame was offered");
        end_test("reset and idle line");
        line_quiet <= 1'b0;
        send_frame(100, 1'b0, -1, 1'b1);
        wait_frames(1);
        end_test("100 byte frame");
        send_frame(20, 1'b0, -1, 1'b1);
        wait_frames(2);
        end_test("20 byte frame with pad");
        send_frame(72, 1'b0, -1, 1'b1);
        send_frame(69, 1'b0, -1, 1'b1);
        wait_frames(4);
        cfg_tx_ifg <= 8'd30;
        repeat (8) @(posedge clk);
        send_frame(66, 1'b0, -1, 1'b1);
        send_frame(72, 1'b0, -1, 1'b1);
        wait_frames(6);
        end_test("inter-frame gap 12 and 30");
        send_frame(64, 1'b0, 3, 1'b1);
        send_frame(48, 1'b1, -1, 1'b1);
        wait_frames(8);
        end_test("underflow and tuser");
        repeat (4) @(posedge clk);
        line_quiet <= 1'b1;
        cfg_tx_enable <= 1'b0;
        send_frame(24, 1'b0, -1, 1'b0);
        repeat (12) @(posedge clk);
        check(rx_starts == 8, "start block sent while disabled");
        line_quiet <= 1'b0;
        cfg_tx_enable <= 1'b1;
        end_test("transmit disabled");
        $display("6 tests, %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* filelist.f */
source/baser_tx_pkg.sv
source/baser_tx_frame_ctrl.sv
source/baser_tx_fcs.sv
source/baser_tx_encoder.sv
source/baser_tx_top.sv
verification/baser_tx_tb.sv

/* Bender.yml */
package:
  name: baser_tx

sources:
  - source/baser_tx_pkg.sv
  - source/baser_tx_frame_ctrl.sv
  - source/baser_tx_fcs.sv
  - source/baser_tx_encoder.sv
  - source/baser_tx_top.sv
  - target: test
    files:
      - verification/baser_tx_tb.sv
